// File: Bender.yml
package:
  name: spif_boot

sources:
  - include_dirs:
      - hw
    files:
      - hw/spif_pkg.sv
      - hw/spram.sv
      - hw/mem_port.sv
      - hw/io_regs.sv
      - hw/boot_loader.sv
      - hw/spif_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/tb_spif.sv

// File: hw/boot_loader.sv
//==========================================================================
// RAM clear and flash stream boot loader
//==========================================================================

`timescale 1ns/1ps
`include "spif_config.svh"

module boot_loader import spif_pkg::*; (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_f_ready,        // flash can take a byte
  input  byte_t      i_f_din,          // byte from the previous transfer
  input  logic       i_u_ready,
  input  logic       i_tx_load,
  input  logic       i_restart,
  output logic       o_f_wr,
  output byte_t      o_f_dout,
  output logic [2:0] o_f_format,
  output logic [3:0] o_f_rate,
  output logic       o_u_wr,
  output logic       o_code_wr,
  output logic       o_data_wr,
  output dest_t      o_dest,
  output cell_t      o_wdata,
  output logic       o_booting,
  output logic       o_p_reset
);

  boot_phase_t  phase;
  stream_mode_t mode;
  logic         clearing;                       // zeroing both RAMs
  logic         code_wr_q;
  logic         data_wr_q;
  count_t       count;                          // words left minus one
  logic [1:0]   bytes;                          // bytes per word minus one
  logic [1:0]   bytecount;
  byte_t        hdr_byte;
  logic         f_ok;

  assign f_ok      = i_f_ready & ~o_f_wr;       // one byte per ready window
  assign o_booting = (phase != IDLE);
  assign o_code_wr = clearing | code_wr_q;
  assign o_data_wr = clearing | data_wr_q;

  always_comb begin
    case (phase)
      HDR_CMD:   hdr_byte = `SPIF_FAST_READ;
      HDR_BLOCK: hdr_byte = `SPIF_BASEBLOCK;   // address bits 23:16
      default:   hdr_byte = 8'h00;             // addr, dummy, stream filler
    endcase
  end

  //========================================================================
  // clear, header sequencer and stream interpreter
  //========================================================================

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      clearing   <= 1'b1;
      phase      <= HDR_CMD;
      mode       <= COMMAND;
      o_f_wr     <= 1'b0;
      o_f_dout   <= 8'h00;
      o_f_format <= 3'b000;
      o_f_rate   <= `SPIF_F_RATE_POR;
      o_u_wr     <= 1'b0;
      o_p_reset  <= 1'b1;
      o_dest     <= '0;
      o_wdata    <= '0;                         // clear writes this zero
      count      <= '0;
      bytes      <= 2'd0;
      bytecount  <= 2'd0;
      code_wr_q  <= 1'b0;
      data_wr_q  <= 1'b0;
    end else begin
      o_u_wr    <= i_tx_load & i_u_ready;
      o_f_wr    <= 1'b0;
      code_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
      if (code_wr_q || data_wr_q) begin
        o_dest <= o_dest + 16'd1;               // bump after each word
      end
      if (clearing) begin
        o_dest <= o_dest + 16'd1;
        if (o_dest[`SPIF_CODE_SIZE-1:0] == '1) begin
          clearing <= 1'b0;
          o_dest   <= '0;
        end
      end else if (i_restart) begin
        phase <= HDR_FIRST;                     // flash is still streaming
        mode  <= COMMAND;
      end else if (f_ok) begin
        case (phase)
          IDLE: o_f_wr <= 1'b0;                 // parked until a restart
          STREAM: begin
            o_f_wr   <= 1'b1;                   // clock in the next byte
            o_f_dout <= 8'h00;
            case (mode)
              COMMAND: begin
                case (i_f_din[7:6])
                  2'b11: begin
                    if (i_f_din[5]) begin
                      o_f_wr     <= 1'b0;       // end of boot
                      o_f_format <= 3'b000;     // CS# goes high
                      o_p_reset  <= i_f_din[4];
                      phase      <= IDLE;
                    end else if (i_f_din[0]) begin
                      mode <= i_f_din[1] ? COUNT_HI : COUNT_LO;
                    end else begin
                      mode <= i_f_din[1] ? DEST_HI : DEST_LO;
                    end
                  end
                  2'b10: o_f_rate <= i_f_din[3:0];
                  default: begin
                    mode      <= i_f_din[2] ? WRITE_DATA : WRITE_CODE;
                    bytes     <= i_f_din[1:0];
                    bytecount <= i_f_din[1:0];
                  end
                endcase
              end
              WRITE_CODE, WRITE_DATA: begin
                o_wdata <= {o_wdata[`SPIF_WIDTH-9:0], i_f_din};  // msb first
                if (bytecount != 2'd0) begin
                  bytecount <= bytecount - 2'd1;
                end else begin
                  bytecount <= bytes;
                  code_wr_q <= (mode == WRITE_CODE);
                  data_wr_q <= (mode == WRITE_DATA);
                  if (count != '0) begin
                    count <= count - 16'd1;
                  end else begin
                    mode <= COMMAND;            // run done
                  end
                end
              end
              DEST_HI: begin
                o_dest[15:8] <= i_f_din;
                mode         <= DEST_LO;
              end
              DEST_LO: begin
                o_dest[7:0] <= i_f_din;
                mode        <= COMMAND;
              end
              COUNT_HI: begin
                count[15:8] <= i_f_din;
                mode        <= COUNT_LO;
              end
              COUNT_LO: begin
                count[7:0] <= i_f_din;
                mode       <= COMMAND;
              end
              default: mode <= COMMAND;
            endcase
          end
          default: begin                        // header bytes
            o_f_wr     <= 1'b1;
            o_f_dout   <= hdr_byte;
            o_f_format <= `SPIF_F_FORMAT_READ;
            phase      <= boot_phase_t'(phase + 3'd1);
          end
        endcase
      end
    end
  end

endmodule

// File: hw/io_regs.sv
//==========================================================================
// Processor I/O registers
//==========================================================================

`timescale 1ns/1ps
`include "spif_config.svh"

module io_regs import spif_pkg::*; (
  input  logic        clk,
  input  logic        arstn,
  input  logic        i_io_rd,
  input  logic        i_io_wr,
  input  io_sel_t     i_sel,
  input  cell_t       i_din,
  input  logic        i_p_hold,
  input  logic        i_u_full,         // UART holds a received byte
  input  byte_t       i_u_din,
  input  logic        i_u_ready,        // UART can take a byte
  input  byte_t       i_f_din,          // last flash result
  input  logic        i_booting,
  output cell_t       o_io_dout,
  output logic        o_u_rd,
  output logic [15:0] o_u_rate,
  output byte_t       o_u_dout,
  output logic        o_tx_load,        // transmit request, one cycle
  output logic        o_restart,        // reinterpret the flash stream
  output logic        o_iobusy          // wait state request
);

  localparam io_sel_t SEL_RXDATA = 3'd0;        // rd byte, wr transmit
  localparam io_sel_t SEL_RXFULL = 3'd1;
  localparam io_sel_t SEL_RATE   = 3'd2;        // rd tx busy, wr baud
  localparam io_sel_t SEL_FLASH  = 3'd3;        // rd flash byte, wr restart
  localparam io_sel_t SEL_BOOT   = 3'd5;
  localparam io_sel_t SEL_CYCLES = 3'd7;

  byte_t rx_byte;
  logic  rx_full;
  logic  tx_sent;                               // u_wr is going out now
  logic  txbusy;
  logic  wr_ok;
  logic  rd_ok;
  cell_t cycles;

  assign wr_ok     = i_io_wr & ~i_p_hold;
  assign rd_ok     = i_io_rd & ~i_p_hold;
  assign txbusy    = ~i_u_ready | tx_sent;
  assign o_tx_load = wr_ok & (i_sel == SEL_RXDATA);
  assign o_restart = wr_ok & (i_sel == SEL_FLASH);
  assign o_iobusy  = i_io_wr & (i_sel == SEL_RXDATA) & txbusy;  // stall emit

  // free-running, wraps at 2^WIDTH
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      cycles <= '0;
    end else begin
      cycles <= cycles + 1'b1;
    end
  end

  //========================================================================
  // receive buffer, one byte deep
  //========================================================================

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rx_byte <= 8'h00;
      rx_full <= 1'b0;
      o_u_rd  <= 1'b0;
    end else begin
      o_u_rd <= 1'b0;
      if (rd_ok && (i_sel == SEL_RXDATA)) begin
        rx_full <= 1'b0;                        // reading the char frees it
      end
      if (i_u_full && !o_u_rd && !rx_full) begin
        o_u_rd  <= 1'b1;                        // take it from the UART
        rx_byte <= i_u_din;
        rx_full <= 1'b1;
      end
    end
  end

  // transmit byte and baud divisor
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_rate <= `SPIF_UART_RATE_POR;
      o_u_dout <= `SPIF_TX_POR;
      tx_sent  <= 1'b0;
    end else begin
      tx_sent <= o_tx_load;
      if (o_tx_load) begin
        o_u_dout <= i_din[7:0];
      end
      if (wr_ok && (i_sel == SEL_RATE)) begin
        o_u_rate <= i_din[15:0];
      end
    end
  end

  // read mux, zero extended
  always_comb begin
    case (i_sel)
      SEL_RXDATA: o_io_dout = cell_t'(rx_byte);
      SEL_RXFULL: o_io_dout = cell_t'(rx_full);
      SEL_RATE:   o_io_dout = cell_t'(txbusy);
      SEL_FLASH:  o_io_dout = cell_t'(i_f_din);
      SEL_BOOT:   o_io_dout = cell_t'(i_booting);
      SEL_CYCLES: o_io_dout = cycles;
      default:    o_io_dout = '0;
    endcase
  end

endmodule

// File: hw/mem_port.sv
//==========================================================================
// Code and data RAMs with boot write path
//==========================================================================

`timescale 1ns/1ps
`include "spif_config.svh"

module mem_port import spif_pkg::*; (
  input  logic       clk,
  input  code_addr_t i_code_addr,      // processor fetch address
  input  bus_addr_t  i_mem_addr,       // processor data address
  input  cell_t      i_din,            // processor store data
  input  logic       i_mem_rd,
  input  logic       i_mem_wr,
  input  logic       i_p_hold,
  input  logic       i_code_wr,        // boot write to code RAM
  input  logic       i_data_wr,        // boot write to data RAM
  input  dest_t      i_dest,           // boot address
  input  cell_t      i_wdata,          // boot word
  output cell_t      o_mem_dout,
  output insn_t      o_insn
);

  code_addr_t code_ia;
  data_addr_t data_ia;
  cell_t      data_din;
  logic       code_rd;
  logic       data_rd;
  logic       data_we;

  // boot side steals the port while it writes
  assign code_ia  = i_code_wr ? i_dest[`SPIF_CODE_SIZE-1:0] : i_code_addr;
  assign code_rd  = ~i_p_hold;                  // fetch only when running
  assign data_ia  = i_data_wr ? i_dest[`SPIF_DATA_SIZE-1:0]
                              : i_mem_addr[`SPIF_DATA_SIZE-1:0];
  assign data_din = i_data_wr ? i_wdata : i_din;
  assign data_we  = i_mem_wr | i_data_wr;
  assign data_rd  = i_mem_rd & ~i_p_hold;

  spram #(
    .ADDR_WIDTH (`SPIF_CODE_SIZE),
    .DATA_WIDTH (16)
  ) code_ram (
    .clk    (clk),
    .i_addr (code_ia),
    .i_din  (i_wdata[15:0]),                    // low 16 bits of the boot word
    .i_we   (i_code_wr),
    .i_re   (code_rd),
    .o_dout (o_insn)
  );

  spram #(
    .ADDR_WIDTH (`SPIF_DATA_SIZE),
    .DATA_WIDTH (`SPIF_WIDTH)
  ) data_ram (
    .clk    (clk),
    .i_addr (data_ia),
    .i_din  (data_din),
    .i_we   (data_we),
    .i_re   (data_rd),
    .o_dout (o_mem_dout)
  );

endmodule

// File: hw/spif_config.svh
//==========================================================================
// Flash boot controller sizes and constants
//==========================================================================

`ifndef SPIF_CONFIG_SVH
`define SPIF_CONFIG_SVH

//==========================================================================
// memory geometry
//==========================================================================

`define SPIF_CODE_SIZE      10          // log2 of code words
`define SPIF_DATA_SIZE      10          // log2 of data cells
`define SPIF_WIDTH          18          // data word width

//==========================================================================
// reset values and flash protocol
//==========================================================================

`define SPIF_BASEBLOCK      8'd0        // first 64KB sector of user flash
`define SPIF_UART_RATE_POR  16'd868     // baud = fclk / this
`define SPIF_FAST_READ      8'h0B       // flash read opcode
`define SPIF_F_RATE_POR     4'd7        // SCLK divisor out of reset
`define SPIF_F_FORMAT_READ  3'b010      // keep CS# low, read transfers
`define SPIF_TX_POR         8'h5B       // first char seen on the UART

`endif

// File: hw/spif_pkg.sv
//==========================================================================
// Flash boot controller types
//==========================================================================

`include "spif_config.svh"

package spif_pkg;

  typedef logic [`SPIF_WIDTH-1:0]     cell_t;       // data word
  typedef logic [15:0]                insn_t;       // instruction word
  typedef logic [7:0]                 byte_t;
  typedef logic [`SPIF_CODE_SIZE-1:0] code_addr_t;
  typedef logic [`SPIF_DATA_SIZE-1:0] data_addr_t;
  typedef logic [14:0]                bus_addr_t;   // processor address
  typedef logic [15:0]                dest_t;       // boot destination
  typedef logic [15:0]                count_t;      // words left in a run
  typedef logic [2:0]                 io_sel_t;     // I/O register select

  // header bytes go out in this order, then the stream
  typedef enum logic [2:0] {
    IDLE, HDR_CMD, HDR_BLOCK, HDR_ADDR_HI, HDR_ADDR_LO, HDR_DUMMY, HDR_FIRST, STREAM
  } boot_phase_t;

  // what the next flash byte means
  typedef enum logic [2:0] {
    COMMAND, WRITE_CODE, WRITE_DATA, DEST_HI, DEST_LO, COUNT_HI, COUNT_LO
  } stream_mode_t;

endpackage

// File: hw/spif_top.sv
//==========================================================================
// Serial flash boot controller
//==========================================================================

`timescale 1ns/1ps

module spif_top import spif_pkg::*; (
  input  logic        clk,
  input  logic        arstn,
  // processor side
  input  logic        i_io_rd,
  input  logic        i_io_wr,
  input  logic        i_mem_rd,
  input  logic        i_mem_wr,
  input  bus_addr_t   i_mem_addr,      // low 3 bits pick the I/O register
  input  cell_t       i_din,
  input  code_addr_t  i_code_addr,
  output cell_t       o_io_dout,
  output cell_t       o_mem_dout,
  output insn_t       o_insn,
  output logic        o_p_hold,
  output logic        o_p_reset,
  // UART side
  input  logic        i_u_ready,
  output logic        o_u_wr,
  output byte_t       o_u_dout,
  input  logic        i_u_full,
  output logic        o_u_rd,
  input  byte_t       i_u_din,
  output logic [15:0] o_u_rate,
  // flash side
  input  logic        i_f_ready,
  output logic        o_f_wr,
  output byte_t       o_f_dout,
  output logic [2:0]  o_f_format,
  output logic [3:0]  o_f_rate,
  input  byte_t       i_f_din
);

  logic  code_wr;
  logic  data_wr;
  logic  iobusy;
  logic  booting;
  logic  tx_load;
  logic  restart;
  dest_t dest;
  cell_t wdata;

  // DMA writes and I/O wait states stall the processor
  assign o_p_hold = code_wr | data_wr | iobusy;

  io_regs u_io_regs (
    .clk       (clk),
    .arstn     (arstn),
    .i_io_rd   (i_io_rd),
    .i_io_wr   (i_io_wr),
    .i_sel     (i_mem_addr[2:0]),
    .i_din     (i_din),
    .i_p_hold  (o_p_hold),
    .i_u_full  (i_u_full),
    .i_u_din   (i_u_din),
    .i_u_ready (i_u_ready),
    .i_f_din   (i_f_din),
    .i_booting (booting),
    .o_io_dout (o_io_dout),
    .o_u_rd    (o_u_rd),
    .o_u_rate  (o_u_rate),
    .o_u_dout  (o_u_dout),
    .o_tx_load (tx_load),
    .o_restart (restart),
    .o_iobusy  (iobusy)
  );

  boot_loader u_boot_loader (
    .clk        (clk),
    .arstn      (arstn),
    .i_f_ready  (i_f_ready),
    .i_f_din    (i_f_din),
    .i_u_ready  (i_u_ready),
    .i_tx_load  (tx_load),
    .i_restart  (restart),
    .o_f_wr     (o_f_wr),
    .o_f_dout   (o_f_dout),
    .o_f_format (o_f_format),
    .o_f_rate   (o_f_rate),
    .o_u_wr     (o_u_wr),
    .o_code_wr  (code_wr),
    .o_data_wr  (data_wr),
    .o_dest     (dest),
    .o_wdata    (wdata),
    .o_booting  (booting),
    .o_p_reset  (o_p_reset)
  );

  mem_port u_mem_port (
    .clk         (clk),
    .i_code_addr (i_code_addr),
    .i_mem_addr  (i_mem_addr),
    .i_din       (i_din),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_p_hold    (o_p_hold),
    .i_code_wr   (code_wr),
    .i_data_wr   (data_wr),
    .i_dest      (dest),
    .i_wdata     (wdata),
    .o_mem_dout  (o_mem_dout),
    .o_insn      (o_insn)
  );

endmodule

// File: hw/spram.sv
//==========================================================================
// Single-port RAM
//==========================================================================

`timescale 1ns/1ps

module spram #(
  parameter int ADDR_WIDTH = 10,               // log2 of depth
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_din,
  input  logic                  i_we,           // write, wins over read
  input  logic                  i_re,           // read, else output holds
  output logic [DATA_WIDTH-1:0] o_dout          // registered read data
);

  logic [DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];

  // one access per cycle, write first
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_din;
    end else if (i_re) begin
      o_dout <= mem[i_addr];                    // data one cycle after address
    end
  end

endmodule

// File: src.f
+incdir+hw
hw/spif_pkg.sv
hw/spram.sv
hw/mem_port.sv
hw/io_regs.sv
hw/boot_loader.sv
hw/spif_top.sv
verif/tb_spif.sv

// File: verif/tb_spif.sv
//==========================================================================
// Flash boot controller testbench
//==========================================================================

`timescale 1ns/1ps
`include "spif_config.svh"

module tb_spif import spif_pkg::*; ();

  localparam int CODE_WORDS = 1 << `SPIF_CODE_SIZE;
  localparam int DATA_WORDS = 1 << `SPIF_DATA_SIZE;

  logic        clk;
  logic        arstn;
  logic        i_io_rd;
  logic        i_io_wr;
  logic        i_mem_rd;
  logic        i_mem_wr;
  bus_addr_t   i_mem_addr;
  cell_t       i_din;
  code_addr_t  i_code_addr;
  cell_t       o_io_dout;
  cell_t       o_mem_dout;
  insn_t       o_insn;
  logic        o_p_hold;
  logic        o_p_reset;
  logic        i_u_ready;
  logic        o_u_wr;
  byte_t       o_u_dout;
  logic        i_u_full;
  logic        o_u_rd;
  byte_t       i_u_din;
  logic [15:0] o_u_rate;
  logic        i_f_ready;
  logic        o_f_wr;
  byte_t       o_f_dout;
  logic [2:0]  o_f_format;
  logic [3:0]  o_f_rate;
  byte_t       i_f_din;

  byte_t      img [$];                          // flash stream after the dummy byte
  byte_t      f_sent [$];                       // every byte the DUT clocked out
  logic [2:0] f_fmt [$];                        // format seen with each byte
  byte_t      rx_q [$];                         // bytes the UART will offer
  insn_t      code_model [0:CODE_WORDS-1];
  cell_t      data_model [0:DATA_WORDS-1];
  logic [3:0] f_rate;                           // rate command value
  logic       end_r;                            // level bit of the end command
  logic       img_ready;
  int         f_gap;
  int         rx_gap;
  int         tx_gap;
  int         rd_pulses;
  int         wr_pulses;
  byte_t      tx_seen;
  int         errors;
  int         tests_run;
  int         tests_failed;

  spif_top UUT (
    .clk        (clk),
    .arstn      (arstn),
    .i_io_rd    (i_io_rd),
    .i_io_wr    (i_io_wr),
    .i_mem_rd   (i_mem_rd),
    .i_mem_wr   (i_mem_wr),
    .i_mem_addr (i_mem_addr),
    .i_din      (i_din),
    .i_code_addr(i_code_addr),
    .o_io_dout  (o_io_dout),
    .o_mem_dout (o_mem_dout),
    .o_insn     (o_insn),
    .o_p_hold   (o_p_hold),
    .o_p_reset  (o_p_reset),
    .i_u_ready  (i_u_ready),
    .o_u_wr     (o_u_wr),
    .o_u_dout   (o_u_dout),
    .i_u_full   (i_u_full),
    .o_u_rd     (o_u_rd),
    .i_u_din    (i_u_din),
    .o_u_rate   (o_u_rate),
    .i_f_ready  (i_f_ready),
    .o_f_wr     (o_f_wr),
    .o_f_dout   (o_f_dout),
    .o_f_format (o_f_format),
    .o_f_rate   (o_f_rate),
    .i_f_din    (i_f_din)
  );

  always #10 clk = ~clk;                        // 20 ns period

  //==========================================================================
  // helpers
  //==========================================================================

  task automatic value_error(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("** Error @ %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("error @ %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_at_start);
    tests_run++;
    if (errors == err_at_start) begin
      $display("test %-9s ok", name);
    end else begin
      $display("test %-9s %0d error(s)", name, errors - err_at_start);
      tests_failed++;
    end
  endtask

  // one I/O read, sampled on the edge that performs it
  task automatic read_io(input io_sel_t sel, output cell_t val);
    i_mem_addr <= {12'd0, sel};
    i_io_rd    <= 1'b1;
    @(posedge clk);
    val = o_io_dout;
    i_io_rd    <= 1'b0;
  endtask

  // write held up until the hold drops, like a stalled core
  task automatic write_io(input io_sel_t sel, input cell_t val);
    i_mem_addr <= {12'd0, sel};
    i_din      <= val;
    i_io_wr    <= 1'b1;
    @(posedge clk);
    while (o_p_hold) @(posedge clk);
    i_io_wr    <= 1'b0;
  endtask

  function automatic byte_t flash_reply(input int k);
    if (k >= 5 && (k - 5) < img.size()) begin
      return img[k - 5];                        // transfer 5 returns the first byte
    end
    return 8'hFF;                               // header transfers read nothing
  endfunction

  // stream image and the RAM contents it should leave behind
  task automatic build_image();
    logic [31:0] rnd;
    logic [15:0] dest;
    logic [15:0] cnt;
    int          n;
    for (int a = 0; a < CODE_WORDS; a++) code_model[a] = '0;
    for (int a = 0; a < DATA_WORDS; a++) data_model[a] = '0;
    rnd    = $urandom;
    f_rate = rnd[3:0];
    img.push_back({4'b1000, f_rate});           // SCLK divisor
    for (int r = 0; r < 6; r++) begin
      rnd  = $urandom;
      dest = 16'($urandom_range(0, CODE_WORDS - 1));
      n    = $urandom_range(1, 8);
      cnt  = 16'(n - 1);
      img.push_back(8'hC2);                     // dest, high byte first
      img.push_back(dest[15:8]);
      img.push_back(dest[7:0]);
      if (r < 3) begin
        img.push_back(8'hC3);                   // count, high byte first
        img.push_back(cnt[15:8]);
        img.push_back(cnt[7:0]);
        img.push_back({1'b0, rnd[3:0], 3'b001}); // code run, 2 bytes per word
      end else begin
        img.push_back(8'hC1);                   // count, low byte only
        img.push_back(cnt[7:0]);
        img.push_back({1'b0, rnd[3:0], 3'b110}); // data run, 3 bytes per word
      end
      for (int i = 0; i < n; i++) begin
        rnd = $urandom;
        if (r >= 3) img.push_back(rnd[23:16]);
        img.push_back(rnd[15:8]);
        img.push_back(rnd[7:0]);
        if (r < 3) code_model[(dest + i) % CODE_WORDS] = rnd[15:0];
        else data_model[(dest + i) % DATA_WORDS] = rnd[17:0];  // top bits drop
      end
    end
    rnd   = $urandom;
    end_r = rnd[4];
    img.push_back({3'b111, end_r, rnd[3:0]});   // end of boot
  endtask

  //==========================================================================
  // flash and UART stubs
  //==========================================================================

  always @(posedge clk) begin
    if (!arstn) begin
      f_gap = 0;
    end else if (o_f_wr) begin
      f_sent.push_back(o_f_dout);
      f_fmt.push_back(o_f_format);
      i_f_ready <= 1'b0;                        // busy shifting
      f_gap = $urandom_range(1, 4);
    end else if (!i_f_ready) begin
      if (f_gap > 1) begin
        f_gap = f_gap - 1;
      end else begin
        i_f_ready <= 1'b1;
        i_f_din   <= flash_reply(f_sent.size() - 1);
      end
    end
  end

  always @(posedge clk) begin
    if (arstn) begin
      if (o_u_rd) begin
        rd_pulses <= rd_pulses + 1;
        i_u_full  <= 1'b0;                      // byte handed over
      end else if (!i_u_full && rx_q.size() > 0) begin
        if (rx_gap > 0) begin
          rx_gap = rx_gap - 1;
        end else begin
          i_u_full <= 1'b1;
          i_u_din  <= rx_q.pop_front();
          rx_gap   = $urandom_range(0, 3);
        end
      end
      if (o_u_wr) begin
        wr_pulses <= wr_pulses + 1;
        tx_seen   <= o_u_dout;
        i_u_ready <= 1'b0;                      // busy sending
        tx_gap    = $urandom_range(2, 6);
      end else if (tx_gap > 0) begin
        tx_gap = tx_gap - 1;
        if (tx_gap == 0) i_u_ready <= 1'b1;
      end
    end
  end

  //==========================================================================
  // watchdog
  //==========================================================================

  initial begin : watchdog
    int limit;
    wait (img_ready);
    limit = CODE_WORDS + 40 * img.size() + 2 * (CODE_WORDS + DATA_WORDS) + 2000;
    repeat (limit) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

  //==========================================================================
  // test sequence
  //==========================================================================

  initial begin : main
    logic [31:0] seed;
    cell_t       val;
    cell_t       c1;
    cell_t       c2;
    cell_t       rate_word;
    byte_t       rx_a;
    byte_t       rx_b;
    byte_t       rx_c;
    byte_t       tx_byte;
    int          err0;
    int          n;
    int          hold_cycles;
    int          rd_base;
    int          wr_base;
    clk         = 1'b0;
    arstn       = 1'b0;
    i_io_rd     = 1'b0;
    i_io_wr     = 1'b0;
    i_mem_rd    = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_addr  = '0;
    i_din       = '0;
    i_code_addr = '0;
    i_u_ready   = 1'b1;
    i_u_full    = 1'b0;
    i_u_din     = 8'h00;
    i_f_ready   = 1'b0;
    i_f_din     = 8'hFF;
    img_ready   = 1'b0;
    errors      = 0;
    tests_run   = 0;
    tests_failed = 0;
    rd_pulses   = 0;
    wr_pulses   = 0;
    rx_gap      = 0;
    tx_gap      = 0;
    tx_seen     = 8'h00;
    seed = $urandom(32'h4ad9);                  // seed once
    build_image();
    img_ready = 1'b1;

    // reset values
    err0 = errors;
    repeat (4) @(posedge clk);
    if (o_p_reset !== 1'b1) value_error("o_p_reset", o_p_reset, 1);
    if (o_u_wr !== 1'b0) value_error("o_u_wr", o_u_wr, 0);
    if (o_u_rd !== 1'b0) value_error("o_u_rd", o_u_rd, 0);
    if (o_f_wr !== 1'b0) value_error("o_f_wr", o_f_wr, 0);
    if (o_f_format !== 3'b000) value_error("o_f_format", o_f_format, 0);
    if (o_u_rate !== `SPIF_UART_RATE_POR) value_error("o_u_rate", o_u_rate, `SPIF_UART_RATE_POR);
    if (o_u_dout !== `SPIF_TX_POR) value_error("o_u_dout", o_u_dout, `SPIF_TX_POR);
    arstn <= 1'b1;
    close_test("reset", err0);

    // RAM clear holds the core for one pass over the code space
    err0 = errors;
    hold_cycles = 0;
    @(posedge clk);
    while (o_p_hold) begin
      hold_cycles++;
      @(posedge clk);
    end
    if (hold_cycles != CODE_WORDS) value_error("clear hold cycles", hold_cycles, CODE_WORDS);
    close_test("clear", err0);

    // wait for the booting flag to drop
    read_io(3'd5, val);
    while (val[0]) read_io(3'd5, val);

    err0 = errors;
    if (f_sent.size() < 6) begin
      report_problem("fewer than six header bytes reached the flash");
    end else begin
      if (f_sent[0] !== `SPIF_FAST_READ) value_error("header byte 0", f_sent[0], `SPIF_FAST_READ);
      if (f_sent[1] !== `SPIF_BASEBLOCK) value_error("header byte 1", f_sent[1], `SPIF_BASEBLOCK);
      for (int i = 2; i < 6; i++) begin
        if (f_sent[i] !== 8'h00) value_error($sformatf("header byte %0d", i), f_sent[i], 0);
      end
      if (f_fmt[5] !== `SPIF_F_FORMAT_READ) value_error("read format", f_fmt[5], `SPIF_F_FORMAT_READ);
    end
    close_test("header", err0);

    err0 = errors;
    if (o_p_reset !== end_r) value_error("o_p_reset after boot", o_p_reset, end_r);
    if (o_f_format !== 3'b000) value_error("o_f_format after boot", o_f_format, 0);
    if (o_f_rate !== f_rate) value_error("o_f_rate", o_f_rate, f_rate);
    if (f_sent.size() != img.size() + 5) value_error("flash transfers", f_sent.size(), img.size() + 5);
    close_test("boot_end", err0);

    // read back every code word
    err0 = errors;
    for (int a = 0; a < CODE_WORDS; a++) begin
      i_code_addr <= code_addr_t'(a);
      repeat (2) @(posedge clk);                // address, then registered data
      if (o_insn !== code_model[a]) value_error($sformatf("code[%0d]", a), o_insn, code_model[a]);
    end
    close_test("code_ram", err0);

    err0 = errors;
    i_mem_rd <= 1'b1;
    for (int a = 0; a < DATA_WORDS; a++) begin
      i_mem_addr <= bus_addr_t'(a);
      repeat (2) @(posedge clk);
      if (o_mem_dout !== data_model[a]) value_error($sformatf("data[%0d]", a), o_mem_dout, data_model[a]);
    end
    i_mem_rd <= 1'b0;
    close_test("data_ram", err0);

    // receive buffer, one byte deep
    err0 = errors;
    rd_base = rd_pulses;
    seed = $urandom;
    rx_a = seed[7:0];
    rx_b = seed[15:8];
    rx_c = seed[23:16];
    rx_q.push_back(rx_a);
    while (rd_pulses == rd_base) @(posedge clk);
    read_io(3'd1, val);
    if (val !== 1) value_error("rx flag with a byte", val, 1);
    read_io(3'd0, val);
    if (val !== rx_a) value_error("rx byte", val, rx_a);
    read_io(3'd1, val);
    if (val !== 0) value_error("rx flag after read", val, 0);
    rx_q.push_back(rx_b);
    while (rd_pulses == rd_base + 1) @(posedge clk);
    rx_q.push_back(rx_c);
    while (!i_u_full) @(posedge clk);           // next byte on offer
    repeat (16) @(posedge clk);
    if (rd_pulses != rd_base + 2) report_problem("o_u_rd pulsed while the rx flag was full");
    read_io(3'd0, val);
    if (val !== rx_b) value_error("rx byte", val, rx_b);
    while (rd_pulses == rd_base + 2) @(posedge clk);
    read_io(3'd0, val);
    if (val !== rx_c) value_error("rx byte", val, rx_c);
    close_test("uart_rx", err0);

    // baud register, then a transmit under back-pressure
    err0 = errors;
    rate_word = cell_t'($urandom);
    write_io(3'd2, rate_word);
    @(posedge clk);
    if (o_u_rate !== rate_word[15:0]) value_error("o_u_rate", o_u_rate, rate_word[15:0]);
    seed    = $urandom;
    tx_byte = seed[7:0];
    wr_base = wr_pulses;
    i_u_ready  <= 1'b0;
    i_mem_addr <= '0;
    i_din      <= {seed[17:8], tx_byte};
    i_io_wr    <= 1'b1;
    repeat ($urandom_range(3, 10)) begin
      @(posedge clk);
      if (!o_p_hold) value_error("o_p_hold under back-pressure", o_p_hold, 1);
    end
    if (wr_pulses != wr_base) report_problem("o_u_wr pulsed while i_u_ready was low");
    i_u_ready <= 1'b1;
    @(posedge clk);
    while (o_p_hold) @(posedge clk);
    i_io_wr <= 1'b0;
    while (wr_pulses == wr_base) @(posedge clk);
    if (tx_seen !== tx_byte) value_error("o_u_dout at o_u_wr", tx_seen, tx_byte);
    repeat (20) @(posedge clk);
    if (wr_pulses != wr_base + 1) value_error("o_u_wr pulses", wr_pulses - wr_base, 1);
    close_test("uart_tx", err0);

    // cycle counter distance
    err0 = errors;
    n = $urandom_range(3, 300);
    read_io(3'd7, c1);
    repeat (n - 1) @(posedge clk);
    read_io(3'd7, c2);
    if (cell_t'(c2 - c1) !== cell_t'(n)) value_error("cycle delta", cell_t'(c2 - c1), n);
    close_test("cycles", err0);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
